/* mmu_top.f */
common/mmu_pkg.sv
systolic_array/mac_pe.sv
systolic_array/systolic_array.sv
rtl/operand_skew.sv
rtl/mmu_sequencer.sv
rtl/mmu_top.sv
dv/mmu_sva.sv
dv/mmu_tb.sv

/* Makefile */
SIM        ?= verilator
TOP        ?= mmu_tb
FILELIST   ?= mmu_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
COMMON     ?= --timing --assert --timescale 1ns/1ps --top-module $(TOP)
LINT_FLAGS ?= --lint-only $(COMMON)
SIM_FLAGS  ?= --binary -j 0 $(COMMON) --Mdir $(BUILD_DIR)
RUN_ARGS   ?= +verilator+error+limit+1000
FAIL_MSG   := TEST RESULT: FAIL
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result line, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/mmu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_tb
    import mmu_pkg::*;
();

    localparam int N               = 4;
    localparam int NUM_MAT         = 25;
    localparam int WATCHDOG_CYCLES = NUM_MAT * (3 * N + 10) + 50;

    localparam int FILL_RANDOM  = 0;
    localparam int FILL_MIN     = 1;
    localparam int FILL_MIXED   = 2;
    localparam int FILL_CHECKER = 3;

    localparam operand_t OP_MIN = 8'sh80;
    localparam operand_t OP_MAX = 8'sh7f;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 start;
    logic                 in_valid;
    logic [N*OP_W-1:0]    a_west;
    logic [N*OP_W-1:0]    b_north;
    logic                 busy;
    logic                 done;
    logic [N*N*ACC_W-1:0] result;

    integer seed         = 32'h11fc_5f60;
    int     value_errors = 0;
    int     flow_errors  = 0;

    // a_m[row][k] and b_m[k][col] of the matrix in flight
    operand_t a_m [N][N];
    operand_t b_m [N][N];

    always #2 clk = ~clk;

    mmu_top #(.N(N)) u_mmu_top (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .in_valid (in_valid),
        .a_west   (a_west),
        .b_north  (b_north),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    bind mmu_top mmu_sva #(.N(N)) u_sva (
        .clk   (clk),
        .rst   (rst),
        .busy  (busy),
        .done  (done),
        .state (u_seq.state)
    );

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    task automatic fill_matrices(input int mode);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                case (mode)
                    FILL_MIN: begin
                        a_m[r][c] = OP_MIN;
                        b_m[r][c] = OP_MIN;
                    end
                    FILL_MIXED: begin
                        a_m[r][c] = OP_MAX;
                        b_m[r][c] = OP_MIN;
                    end
                    FILL_CHECKER: begin
                        a_m[r][c] = ((r + c) % 2 == 0) ? OP_MIN : OP_MAX;
                        b_m[r][c] = ((r + c) % 2 == 0) ? OP_MAX : OP_MIN;
                    end
                    default: begin
                        a_m[r][c] = operand_t'($random(seed));
                        b_m[r][c] = operand_t'($random(seed));
                    end
                endcase
            end
        end
    endtask

    // column k of A on the west lanes, row k of B on the north lanes
    task automatic drive_step(input int k);
        for (int l = 0; l < N; l++) begin
            a_west[l*OP_W +: OP_W]  = a_m[l][k];
            b_north[l*OP_W +: OP_W] = b_m[k][l];
        end
    endtask

    // garbage on the lanes in slots that carry no step
    task automatic drive_junk();
        for (int l = 0; l < N; l++) begin
            a_west[l*OP_W +: OP_W]  = operand_t'($random(seed));
            b_north[l*OP_W +: OP_W] = operand_t'($random(seed));
        end
    endtask

    task automatic expect_busy();
        assert (busy) else begin
            flow_errors++;
            $display("Mismatch busy: expected %h, got %h", 1'b1, busy);
        end
    endtask

    task automatic check_product();
        int   exp;
        acc_t got;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                exp = 0;
                for (int k = 0; k < N; k++) begin
                    exp += int'(a_m[i][k]) * int'(b_m[k][j]);
                end
                got = result[(i*N+j)*ACC_W +: ACC_W];
                assert (got == acc_t'(exp)) else begin
                    value_errors++;
                    $display("Mismatch result[%0d][%0d]: expected %h, got %h",
                             i, j, acc_t'(exp), got);
                end
            end
        end
    endtask

    // called on a falling edge, returns on the falling edge that sees done
    task automatic run_matrix(input bit use_gaps, input bit poke);
        bit gap;
        int lat;
        start    = 1'b1;
        in_valid = 1'b1;
        drive_step(0);
        for (int k = 1; k < N; k++) begin
            gap = use_gaps && ($random(seed) % 2 != 0);
            @(negedge clk);
            expect_busy();
            if (gap) begin
                start    = 1'b0;
                in_valid = 1'b0;
                drive_junk();
                @(negedge clk);
                expect_busy();
            end
            // stray start riding on step 1 while loading
            start    = poke && (k == 1);
            in_valid = 1'b1;
            drive_step(k);
        end
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            // stray start with junk during the first drain cycle
            start    = poke && (lat == 1);
            in_valid = poke && (lat == 1);
            drive_junk();
            if (!done) begin
                expect_busy();
            end
        end while (!done);
        assert (lat == 2 * N + 1) else begin
            flow_errors++;
            $display("Mismatch done latency: expected %h, got %h", 2 * N + 1, lat);
        end
        check_product();
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        start    = 1'b0;
        in_valid = 1'b0;
        a_west   = '0;
        b_north  = '0;
        rst      = 1'b0;
        #1 rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // odd ones get idle gaps, each starts right as busy falls
        for (int m = 0; m < 20; m++) begin
            fill_matrices(FILL_RANDOM);
            run_matrix(m % 2 == 1, 1'b0);
        end
        for (int m = 0; m < 2; m++) begin
            fill_matrices(FILL_RANDOM);
            run_matrix(1'b1, 1'b1);
        end
        fill_matrices(FILL_MIN);
        run_matrix(1'b0, 1'b0);
        fill_matrices(FILL_MIXED);
        run_matrix(1'b0, 1'b0);
        fill_matrices(FILL_CHECKER);
        run_matrix(1'b1, 1'b0);

        // let the last done pass through the bound checks
        start    = 1'b0;
        in_valid = 1'b0;
        repeat (3) @(negedge clk);

        $display("summary: %0d value errors, %0d flow errors, %0d assertion failures",
                 value_errors, flow_errors, u_mmu_top.u_sva.fail_count);
        if (value_errors == 0 && flow_errors == 0 && u_mmu_top.u_sva.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the DUT did not finish %0d matrices within %0d cycles",
                 NUM_MAT, WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule : mmu_tb

`default_nettype wire

/* dv/mmu_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_sva
    import mmu_pkg::*;
#(
    parameter int N = 4
) (
    input logic       clk,
    input logic       rst,
    input logic       busy,
    input logic       done,
    input seq_state_t state
);

    // one tally per check, summed for the testbench
    int unsigned latency_fails = 0;
    int unsigned origin_fails  = 0;
    int unsigned pulse_fails   = 0;
    int unsigned busy_fails    = 0;
    int unsigned reset_fails   = 0;
    int unsigned fail_count;

    assign fail_count = latency_fails + origin_fails + pulse_fails + busy_fails + reset_fails;

    //////////////////////////////
    // done timing
    //////////////////////////////

    // leaving LOAD marks the edge that took the last step
    a_done_after_drain: assert property (@(posedge clk) disable iff (rst)
        (state == DRAIN && $past(state) == LOAD) |-> ##(2*N) done) else begin
        latency_fails++;
        $error("done missing 2N+1 edges after the last step");
    end

    a_done_origin: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> ($past(state, 2*N) == DRAIN && $past(state, 2*N+1) == LOAD)) else begin
        origin_fails++;
        $error("done rose without a last step 2N+1 edges earlier");
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done) else begin
        pulse_fails++;
        $error("done stayed high longer than one cycle");
    end

    a_busy_with_done: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $fell(busy)) else begin
        busy_fails++;
        $error("busy did not fall on the edge that raised done");
    end

    //////////////////////////////
    // reset
    //////////////////////////////

    a_reset_quiet: assert property (@(posedge clk)
        (rst || $past(rst)) |-> (!busy && !done)) else begin
        reset_fails++;
        $error("busy or done high during or right after reset");
    end

endmodule : mmu_sva

`default_nettype wire

/* rtl/mmu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_top
    import mmu_pkg::*;
#(
    parameter int N = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 in_valid,
    input  logic [N*OP_W-1:0]    a_west,
    input  logic [N*OP_W-1:0]    b_north,
    output logic                 busy,
    output logic                 done,
    output logic [N*N*ACC_W-1:0] result
);

    logic              step_en;
    logic              step_first;
    logic [N*OP_W-1:0] west_lanes;
    logic [N-1:0]      west_first;
    logic [N*OP_W-1:0] north_lanes;

    //////////////////////////////
    // control
    //////////////////////////////

    mmu_sequencer #(.N(N)) u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .in_valid   (in_valid),
        .step_en    (step_en),
        .step_first (step_first),
        .busy       (busy),
        .done       (done)
    );

    //////////////////////////////
    // datapath
    //////////////////////////////

    operand_skew #(.N(N)) u_skew (
        .clk         (clk),
        .rst         (rst),
        .step_en     (step_en),
        .step_first  (step_first),
        .a_west      (a_west),
        .b_north     (b_north),
        .west_lanes  (west_lanes),
        .west_first  (west_first),
        .north_lanes (north_lanes)
    );

    systolic_array #(.N(N)) u_array (
        .clk         (clk),
        .rst         (rst),
        .west_lanes  (west_lanes),
        .west_first  (west_first),
        .north_lanes (north_lanes),
        .acc_flat    (result)
    );

endmodule : mmu_top

`default_nettype wire

/* rtl/mmu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_sequencer
    import mmu_pkg::*;
#(
    parameter int N = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic in_valid,
    output logic step_en,
    output logic step_first,
    output logic busy,
    output logic done
);

    localparam int STEP_W  = $clog2(N);
    localparam int DRAIN_W = $clog2(2 * N);

    localparam logic [STEP_W-1:0]  LAST_STEP  = STEP_W'(N - 1);
    localparam logic [DRAIN_W-1:0] LAST_DRAIN = DRAIN_W'(2 * N - 1);

    seq_state_t          state;
    logic [STEP_W-1:0]   step_cnt;
    logic [DRAIN_W-1:0]  drain_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            step_cnt   <= '0;
            drain_cnt  <= '0;
            step_en    <= 1'b0;
            step_first <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            // strobes last one cycle
            step_en    <= 1'b0;
            step_first <= 1'b0;
            done       <= 1'b0;
            case (state)
                IDLE: begin
                    // start carries step 0
                    if (start && in_valid) begin
                        state      <= LOAD;
                        step_cnt   <= STEP_W'(1);
                        step_en    <= 1'b1;
                        step_first <= 1'b1;
                        busy       <= 1'b1;
                    end
                end
                LOAD: begin
                    // start is ignored here, gaps just wait
                    if (in_valid) begin
                        step_en <= 1'b1;
                        if (step_cnt == LAST_STEP) begin
                            state     <= DRAIN;
                            drain_cnt <= '0;
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    // wait for the last step to reach the far corner
                    if (drain_cnt == LAST_DRAIN) begin
                        state <= IDLE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule : mmu_sequencer

`default_nettype wire

/* rtl/operand_skew.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_skew
    import mmu_pkg::*;
#(
    parameter int N = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              step_en,
    input  logic              step_first,
    input  logic [N*OP_W-1:0] a_west,
    input  logic [N*OP_W-1:0] b_north,
    output logic [N*OP_W-1:0] west_lanes,
    output logic [N-1:0]      west_first,
    output logic [N*OP_W-1:0] north_lanes
);

    // raw lane capture, lines up with the registered step_en
    logic [N*OP_W-1:0] a_cap;
    logic [N*OP_W-1:0] b_cap;

    // gated lanes, zero in slots that carry no step
    operand_t a_gate [N];
    operand_t b_gate [N];
    logic     first_gate;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_cap      <= '0;
            b_cap      <= '0;
            a_gate     <= '{default: '0};
            b_gate     <= '{default: '0};
            first_gate <= 1'b0;
        end else begin
            a_cap      <= a_west;
            b_cap      <= b_north;
            first_gate <= step_first;
            for (int i = 0; i < N; i++) begin
                a_gate[i] <= step_en ? operand_t'(a_cap[i*OP_W +: OP_W]) : '0;
                b_gate[i] <= step_en ? operand_t'(b_cap[i*OP_W +: OP_W]) : '0;
            end
        end
    end

    //////////////////////////////
    // per-lane delay chains
    //////////////////////////////

    for (genvar i = 0; i < N; i++) begin : g_lane
        if (i == 0) begin : g_direct
            assign west_lanes[0 +: OP_W]  = a_gate[0];
            assign north_lanes[0 +: OP_W] = b_gate[0];
            assign west_first[0]          = first_gate;
        end else begin : g_delay
            // lane i waits i cycles so it meets its partner in the grid
            operand_t a_pipe [i];
            operand_t b_pipe [i];
            logic     f_pipe [i];

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    a_pipe <= '{default: '0};
                    b_pipe <= '{default: '0};
                    f_pipe <= '{default: 1'b0};
                end else begin
                    a_pipe[0] <= a_gate[i];
                    b_pipe[0] <= b_gate[i];
                    f_pipe[0] <= first_gate;
                    for (int k = 1; k < i; k++) begin
                        a_pipe[k] <= a_pipe[k-1];
                        b_pipe[k] <= b_pipe[k-1];
                        f_pipe[k] <= f_pipe[k-1];
                    end
                end
            end

            assign west_lanes[i*OP_W +: OP_W]  = a_pipe[i-1];
            assign north_lanes[i*OP_W +: OP_W] = b_pipe[i-1];
            assign west_first[i]               = f_pipe[i-1];
        end
    end

endmodule : operand_skew

`default_nettype wire

/* systolic_array/systolic_array.sv */
`timescale 1ns/1ps
`default_nettype none

module systolic_array
    import mmu_pkg::*;
#(
    parameter int N = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [N*OP_W-1:0] west_lanes,
    input  logic [N-1:0]      west_first,
    input  logic [N*OP_W-1:0] north_lanes,
    output logic [N*N*ACC_W-1:0] acc_flat
);

    // east_op[i][j] and south_op[i][j] feed cell (i,j)
    // the extra column and row catch the outputs of the far edge
    operand_t east_op    [N][N+1];
    logic     east_first [N][N+1];
    operand_t south_op   [N+1][N];

    //////////////////////////////
    // edge lanes
    //////////////////////////////

    for (genvar i = 0; i < N; i++) begin : g_west_edge
        assign east_op[i][0]    = west_lanes[i*OP_W +: OP_W];
        assign east_first[i][0] = west_first[i];
    end

    for (genvar j = 0; j < N; j++) begin : g_north_edge
        assign south_op[0][j] = north_lanes[j*OP_W +: OP_W];
    end

    //////////////////////////////
    // cell grid
    //////////////////////////////

    for (genvar i = 0; i < N; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            mac_pe u_pe (
                .clk            (clk),
                .rst            (rst),
                .west_in        (east_op[i][j]),
                .west_first_in  (east_first[i][j]),
                .north_in       (south_op[i][j]),
                .east_out       (east_op[i][j+1]),
                .east_first_out (east_first[i][j+1]),
                .south_out      (south_op[i+1][j]),
                .acc            (acc_flat[(i*N+j)*ACC_W +: ACC_W])
            );
        end
    end

endmodule : systolic_array

`default_nettype wire

/* systolic_array/mac_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_pe
    import mmu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  operand_t west_in,
    input  logic     west_first_in,
    input  operand_t north_in,
    output operand_t east_out,
    output logic     east_first_out,
    output operand_t south_out,
    output acc_t     acc
);

    // full-precision signed product of the two operands
    logic signed [2*OP_W-1:0] prod;

    assign prod = west_in * north_in;

    // operands hop one cell per cycle, tag travels with the row operand
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            east_out       <= '0;
            east_first_out <= 1'b0;
            south_out      <= '0;
        end else begin
            east_out       <= west_in;
            east_first_out <= west_first_in;
            south_out      <= north_in;
        end
    end

    // first step of a matrix restarts the sum
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (west_first_in) begin
            acc <= acc_t'(prod);
        end else begin
            acc <= acc + acc_t'(prod);
        end
    end

endmodule : mac_pe

`default_nettype wire

/* common/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    //////////////////////////////
    // operand and result types
    //////////////////////////////

    // one matrix element as streamed by the caller
    typedef logic signed [7:0] operand_t;

    // one accumulated dot product, wide enough for N up to 2^16
    typedef logic signed [31:0] acc_t;

    localparam int OP_W  = $bits(operand_t);
    localparam int ACC_W = $bits(acc_t);

    //////////////////////////////
    // sequencer states
    //////////////////////////////

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        DRAIN
    } seq_state_t;

endpackage : mmu_pkg

`default_nettype wire
